// ==== project.f ====
src/rom_ctrl_pkg.sv
src/rom_ctrl_counter.sv
src/rom_ctrl_hash.sv
src/rom_ctrl_compare.sv
src/rom_ctrl_fsm.sv
src/rom_ctrl_mux.sv
src/rom_ctrl_top.sv
sim/rom_ctrl_chk.sv
sim/rom_ctrl_tb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/10ps
TOP      = rom_ctrl_tb
FILELIST = project.f
OBJ_DIR  = obj_dir

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/rom_ctrl_tb.sv ====
// ROM checker testbench
`timescale 1ns/10ps

module rom_ctrl_tb;
  import rom_ctrl_pkg::*;

  localparam int NumTests   = 5;
  localparam int NumReads   = 16;
  localparam int CycleLimit = NumTests * (RomDepth * 3 + 50);

  logic               clk_i;
  logic               rst_ni;
  logic               bus_req;
  logic [AddrW-1:0]   bus_addr;
  logic [31:0]        rom_data;
  logic               rom_req;
  logic [AddrW-1:0]   rom_addr;
  logic               bus_gnt;
  logic               bus_rvalid;
  logic [31:0]        bus_rdata;
  logic               pwr_done;
  logic               pwr_good;
  logic               keymgr_valid;
  logic [DigestW-1:0] keymgr_data;
  logic [DigestW-1:0] digest;
  logic [DigestW-1:0] exp_digest;
  logic               alert;

  // ROM array and the request seen at the last clock edge
  logic [31:0]        rom_mem [RomDepth];
  logic               rd_req;
  logic [AddrW-1:0]   rd_addr;

  int                 seed;
  int                 err_cnt;
  int                 check_cnt;
  int                 test_start;
  int                 cycle_cnt = 0;
  string              test_name;
  logic               alert_seen;
  logic               gnt_seen;

  rom_ctrl_top rom_ctrl_top_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .bus_req_i      (bus_req),
    .bus_addr_i     (bus_addr),
    .rom_data_i     (rom_data),
    .rom_req_o      (rom_req),
    .rom_addr_o     (rom_addr),
    .bus_gnt_o      (bus_gnt),
    .bus_rvalid_o   (bus_rvalid),
    .bus_rdata_o    (bus_rdata),
    .pwr_done_o     (pwr_done),
    .pwr_good_o     (pwr_good),
    .keymgr_valid_o (keymgr_valid),
    .keymgr_data_o  (keymgr_data),
    .digest_o       (digest),
    .exp_digest_o   (exp_digest),
    .alert_o        (alert)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // ROM model with one cycle of read latency
  always @(posedge clk_i) begin
    rd_req  = rom_req;
    rd_addr = rom_addr;
    #1;
    if (rd_req) begin
      rom_data = rom_mem[rd_addr];
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  initial begin
    wait (cycle_cnt >= CycleLimit);
    $display("Timeout after %0d cycles in test %s", cycle_cnt, test_name);
    $display("Result: FAILED");
    $finish;
  end

  // Alerts and early grants are illegal at any point, so watch every cycle
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (alert && !alert_seen) begin
        alert_seen = 1'b1;
        err_cnt++;
        $display("ERROR t=%0t alert_o was raised in test %s", $time, test_name);
      end
      if (bus_gnt && !pwr_done && !gnt_seen) begin
        gnt_seen = 1'b1;
        err_cnt++;
        $display("ERROR t=%0t bus granted before the check ended in test %s",
                 $time, test_name);
      end
    end
  end

  function automatic logic [31:0] rot_left(input logic [31:0] x, input int unsigned amt);
    return (x << amt) | (x >> (32 - amt));
  endfunction

  // Expected digest over the low region of the ROM model
  function automatic logic [DigestW-1:0] ref_digest();
    logic [31:0]        st [TopCount];
    logic [DigestW-1:0] res;
    for (int k = 0; k < TopCount; k++) begin
      st[k] = IvBase + 32'(k);
    end
    for (int n = 0; n < LowCount; n++) begin
      st[n % TopCount] = (rot_left(st[n % TopCount], AbsorbRot) ^ rom_mem[n]) + 32'(n);
    end
    // Rounds run in order and see the words already updated
    for (int r = 0; r < TopCount; r++) begin
      st[r] = st[r] ^ rot_left(st[(r + 1) % TopCount], FinalRot);
    end
    for (int k = 0; k < TopCount; k++) begin
      res[k*32 +: 32] = st[k];
    end
    return res;
  endfunction

  task automatic check_digest(input string name, input logic [DigestW-1:0] got,
                              input logic [DigestW-1:0] exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("MISMATCH t=%0t %s got=%h exp=%h", $time, name, got, exp);
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("MISMATCH t=%0t %s got=%h exp=%h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("MISMATCH t=%0t %s got=%b exp=%b", $time, name, got, exp);
    end
  endtask

  task automatic step_clk();
    @(posedge clk_i);
    #1;
  endtask

  // Random words everywhere, then the top region holds the true digest
  task automatic fill_rom(input bit corrupt);
    logic [DigestW-1:0] dig;
    logic [31:0]        rnd;
    int                 idx;
    for (int a = 0; a < RomDepth; a++) begin
      rom_mem[a] = $random(seed);
    end
    dig = ref_digest();
    for (int k = 0; k < TopCount; k++) begin
      rom_mem[LowCount + k] = dig[k*32 +: 32];
    end
    if (corrupt) begin
      rnd = $random(seed);
      idx = int'(rnd[IdxW-1:0]);
      rom_mem[LowCount + idx] = rom_mem[LowCount + idx] ^ (32'h1 << rnd[12:8]);
    end
  endtask

  task automatic reset_dut();
    rst_ni     = 1'b0;
    alert_seen = 1'b0;
    gnt_seen   = 1'b0;
    @(negedge clk_i);
    check_bit("pwr_done_o", pwr_done, 1'b0);
    check_bit("pwr_good_o", pwr_good, 1'b0);
    check_bit("keymgr_valid_o", keymgr_valid, 1'b0);
    check_bit("alert_o", alert, 1'b0);
    check_bit("bus_gnt_o", bus_gnt, 1'b0);
    check_bit("bus_rvalid_o", bus_rvalid, 1'b0);
    check_bit("hash_valid", rom_ctrl_top_i.hash_valid, 1'b0);
    repeat (2) step_clk();
    rst_ni = 1'b1;
  endtask

  // Returns at a falling edge with pwr_done_o high
  task automatic wait_done();
    @(negedge clk_i);
    while (!pwr_done) begin
      @(negedge clk_i);
    end
  endtask

  task automatic begin_test(input string name);
    test_name  = name;
    test_start = err_cnt;
    step_clk();
  endtask

  task automatic end_test();
    if (err_cnt == test_start) begin
      $display("test %s: ok", test_name);
    end else begin
      $display("test %s: %0d errors", test_name, err_cnt - test_start);
    end
  endtask

  initial begin
    logic [DigestW-1:0] exp;
    logic [DigestW-1:0] exp_top;
    logic [31:0]        rnd;
    rst_ni     = 1'b0;
    bus_req    = 1'b0;
    bus_addr   = '0;
    rom_data   = '0;
    seed       = 32'h57d6_fd3d;
    err_cnt    = 0;
    check_cnt  = 0;
    alert_seen = 1'b0;
    gnt_seen   = 1'b0;
    test_name  = "startup";

    begin_test("matching_rom");
    fill_rom(1'b0);
    exp = ref_digest();
    reset_dut();
    wait_done();
    check_bit("pwr_good_o", pwr_good, 1'b1);
    check_bit("keymgr_valid_o", keymgr_valid, 1'b1);
    check_bit("alert_o", alert, 1'b0);
    check_digest("digest_o", digest, exp);
    check_digest("exp_digest_o", exp_digest, exp);
    end_test();

    begin_test("corrupt_top");
    fill_rom(1'b1);
    exp = ref_digest();
    for (int k = 0; k < TopCount; k++) begin
      exp_top[k*32 +: 32] = rom_mem[LowCount + k];
    end
    reset_dut();
    wait_done();
    check_bit("pwr_good_o", pwr_good, 1'b0);
    check_bit("alert_o", alert, 1'b0);
    check_digest("exp_digest_o", exp_digest, exp_top);
    check_digest("digest_o", digest, exp);
    end_test();

    begin_test("keymgr_handover");
    fill_rom(1'b0);
    exp = ref_digest();
    reset_dut();
    @(negedge clk_i);
    while (!keymgr_valid) begin
      @(negedge clk_i);
    end
    check_bit("pwr_done_o", pwr_done, 1'b1);
    check_digest("keymgr_data_o", keymgr_data, exp);
    // Both flags stay up once the handover has happened
    repeat (4) begin
      @(negedge clk_i);
      check_bit("keymgr_valid_o", keymgr_valid, 1'b1);
      check_bit("pwr_done_o", pwr_done, 1'b1);
    end
    end_test();

    begin_test("bus_holdoff");
    fill_rom(1'b0);
    rnd      = $random(seed);
    bus_addr = rnd[AddrW-1:0];
    bus_req  = 1'b1;
    reset_dut();
    wait_done();
    check_bit("bus_gnt_o", bus_gnt, 1'b1);
    @(negedge clk_i);
    check_bit("bus_rvalid_o", bus_rvalid, 1'b1);
    check_word("bus_rdata_o", bus_rdata, rom_mem[bus_addr]);
    step_clk();
    bus_req = 1'b0;
    end_test();

    begin_test("random_bus_reads");
    fill_rom(1'b0);
    reset_dut();
    wait_done();
    for (int i = 0; i < NumReads; i++) begin
      step_clk();
      rnd      = $random(seed);
      bus_addr = rnd[AddrW-1:0];
      bus_req  = 1'b1;
      @(negedge clk_i);
      check_bit("bus_gnt_o", bus_gnt, 1'b1);
      step_clk();
      bus_req = 1'b0;
      @(negedge clk_i);
      check_bit("bus_rvalid_o", bus_rvalid, 1'b1);
      check_word("bus_rdata_o", bus_rdata, rom_mem[bus_addr]);
    end
    end_test();

    $display("Tests %0d, checks %0d, errors %0d", NumTests, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== sim/rom_ctrl_chk.sv ====
// Digest stream and handover assertions
`timescale 1ns/10ps

module rom_ctrl_chk (
  input logic        clk_i,
  input logic        rst_ni,
  input logic        hash_valid_i,
  input logic        hash_last_i,
  input logic        hash_ready_i,
  input logic [31:0] hash_data_i,
  input logic        done_i,
  input logic        bus_gnt_i
);

  // Last only ever marks a word that is actually offered
  last_has_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    hash_last_i |-> hash_valid_i)
    else $error("hash_last seen without hash_valid");

  // A stalled word keeps its valid and its data until the engine takes it
  valid_holds: assert property (@(posedge clk_i) disable iff (!rst_ni)
    hash_valid_i && !hash_ready_i |=> hash_valid_i && $stable(hash_data_i))
    else $error("hash stream word dropped or changed before ready");

  // The check result is final until the next reset
  done_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_i |=> done_i)
    else $error("check done fell without reset");

  // The ROM belongs to the checker until it is done
  no_early_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_gnt_i |-> done_i)
    else $error("bus granted before check done");

endmodule

// Stream wires and the bus grant are both visible in the top level
bind rom_ctrl_top rom_ctrl_chk u_chk (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .hash_valid_i (hash_valid),
  .hash_last_i  (hash_last),
  .hash_ready_i (hash_ready),
  .hash_data_i  (hash_data),
  .done_i       (pwr_done_o),
  .bus_gnt_i    (bus_gnt_o)
);

// ==== src/rom_ctrl_top.sv ====
// ROM integrity checker top level
`timescale 1ns/10ps

module rom_ctrl_top (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             bus_req_i,
  input  logic [rom_ctrl_pkg::AddrW-1:0]   bus_addr_i,
  input  logic [31:0]                      rom_data_i,
  output logic                             rom_req_o,
  output logic [rom_ctrl_pkg::AddrW-1:0]   rom_addr_o,
  output logic                             bus_gnt_o,
  output logic                             bus_rvalid_o,
  output logic [31:0]                      bus_rdata_o,
  output logic                             pwr_done_o,
  output logic                             pwr_good_o,
  output logic                             keymgr_valid_o,
  output logic [rom_ctrl_pkg::DigestW-1:0] keymgr_data_o,
  output logic [rom_ctrl_pkg::DigestW-1:0] digest_o,
  output logic [rom_ctrl_pkg::DigestW-1:0] exp_digest_o,
  output logic                             alert_o
);

  // Digest stream between sequencer and engine
  logic                             hash_valid;
  logic                             hash_last;
  logic                             hash_ready;
  logic                             hash_done;
  logic                             hash_err;
  logic [31:0]                      hash_data;
  logic [rom_ctrl_pkg::DigestW-1:0] hash_digest;

  // Checker side of the ROM port
  logic                           chk_req;
  logic [rom_ctrl_pkg::AddrW-1:0] chk_addr;

  rom_ctrl_fsm u_fsm (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .hash_ready_i   (hash_ready),
    .hash_done_i    (hash_done),
    .hash_err_i     (hash_err),
    .hash_digest_i  (hash_digest),
    .rom_data_i     (rom_data_i),
    .hash_valid_o   (hash_valid),
    .hash_last_o    (hash_last),
    .rom_req_o      (chk_req),
    .done_o         (pwr_done_o),
    .good_o         (pwr_good_o),
    .keymgr_valid_o (keymgr_valid_o),
    .alert_o        (alert_o),
    .rom_addr_o     (chk_addr),
    .hash_data_o    (hash_data),
    .keymgr_data_o  (keymgr_data_o),
    .digest_o       (digest_o),
    .exp_digest_o   (exp_digest_o)
  );

  rom_ctrl_hash u_hash (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .valid_i  (hash_valid),
    .last_i   (hash_last),
    .data_i   (hash_data),
    .ready_o  (hash_ready),
    .done_o   (hash_done),
    .err_o    (hash_err),
    .digest_o (hash_digest)
  );

  // The bus is only handed the ROM once the check is done
  rom_ctrl_mux u_mux (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .sel_bus_i    (pwr_done_o),
    .chk_req_i    (chk_req),
    .bus_req_i    (bus_req_i),
    .chk_addr_i   (chk_addr),
    .bus_addr_i   (bus_addr_i),
    .rom_data_i   (rom_data_i),
    .rom_req_o    (rom_req_o),
    .bus_gnt_o    (bus_gnt_o),
    .bus_rvalid_o (bus_rvalid_o),
    .rom_addr_o   (rom_addr_o),
    .bus_rdata_o  (bus_rdata_o)
  );

endmodule

// ==== src/rom_ctrl_mux.sv ====
// ROM port arbiter
`timescale 1ns/10ps

module rom_ctrl_mux (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           sel_bus_i,
  input  logic                           chk_req_i,
  input  logic                           bus_req_i,
  input  logic [rom_ctrl_pkg::AddrW-1:0] chk_addr_i,
  input  logic [rom_ctrl_pkg::AddrW-1:0] bus_addr_i,
  input  logic [31:0]                    rom_data_i,
  output logic                           rom_req_o,
  output logic                           bus_gnt_o,
  output logic                           bus_rvalid_o,
  output logic [rom_ctrl_pkg::AddrW-1:0] rom_addr_o,
  output logic [31:0]                    bus_rdata_o
);

  logic rvalid_q;

  // The checker owns the ROM until select, and the bus request simply waits
  assign bus_gnt_o  = sel_bus_i & bus_req_i;
  assign rom_req_o  = sel_bus_i ? bus_req_i : chk_req_i;
  assign rom_addr_o = sel_bus_i ? bus_addr_i : chk_addr_i;

  // Read data comes back one cycle after the grant
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus_gnt_o;
    end
  end

  // Words fetched by the checker are never shown on the bus
  assign bus_rvalid_o = rvalid_q;
  assign bus_rdata_o  = rvalid_q ? rom_data_i : '0;

endmodule

// ==== src/rom_ctrl_fsm.sv ====
// ROM check sequencer
`timescale 1ns/10ps

module rom_ctrl_fsm (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             hash_ready_i,
  input  logic                             hash_done_i,
  input  logic                             hash_err_i,
  input  logic [rom_ctrl_pkg::DigestW-1:0] hash_digest_i,
  input  logic [31:0]                      rom_data_i,
  output logic                             hash_valid_o,
  output logic                             hash_last_o,
  output logic                             rom_req_o,
  output logic                             done_o,
  output logic                             good_o,
  output logic                             keymgr_valid_o,
  output logic                             alert_o,
  output logic [rom_ctrl_pkg::AddrW-1:0]   rom_addr_o,
  output logic [31:0]                      hash_data_o,
  output logic [rom_ctrl_pkg::DigestW-1:0] keymgr_data_o,
  output logic [rom_ctrl_pkg::DigestW-1:0] digest_o,
  output logic [rom_ctrl_pkg::DigestW-1:0] exp_digest_o
);
  import rom_ctrl_pkg::*;

  fsm_state_e       state_d, state_q;
  logic             counter_done;
  logic             counter_req;
  logic             counter_lnt;
  logic             counter_data_rdy;
  logic [AddrW-1:0] counter_read_addr;
  logic [AddrW-1:0] counter_data_addr;
  logic [AddrW-1:0] rel_addr;
  logic             start_q;
  logic             checker_done;
  logic             checker_good;
  logic             checker_alert;
  logic             exp_vld;
  logic             in_done;
  logic             fsm_alert;
  logic             counter_lost;
  logic             hash_vld_d, hash_vld_q;

  rom_ctrl_counter u_counter (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .data_rdy_i         (counter_data_rdy),
    .done_o             (counter_done),
    .read_req_o         (counter_req),
    .data_last_nontop_o (counter_lnt),
    .read_addr_o        (counter_read_addr),
    .data_addr_o        (counter_data_addr)
  );

  rom_ctrl_compare u_compare (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .start_i      (start_q),
    .digest_vld_i (hash_done_i),
    .exp_vld_i    (exp_vld),
    .digest_i     (hash_digest_i),
    .exp_word_i   (rom_data_i),
    .exp_idx_i    (rel_addr[IdxW-1:0]),
    .done_o       (checker_done),
    .good_o       (checker_good),
    .alert_o      (checker_alert),
    .digest_o     (digest_o),
    .exp_digest_o (exp_digest_o)
  );

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ReadingLow;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d   = state_q;
    fsm_alert = 1'b0;
    case (state_q)
      // Low region goes to the engine until the last word is accepted
      ReadingLow: begin
        if (counter_lnt && hash_ready_i && hash_valid_o) begin
          state_d = ReadingHigh;
        end
      end
      // Top region reads race with finalisation in the engine
      ReadingHigh: begin
        case ({hash_done_i, counter_done})
          2'b01:   state_d = RomAhead;
          2'b10:   state_d = KmacAhead;
          2'b11:   state_d = Checking;
          default: state_d = ReadingHigh;
        endcase
      end
      RomAhead: begin
        if (hash_done_i) begin
          state_d = Checking;
        end
      end
      KmacAhead: begin
        if (counter_done) begin
          state_d = Checking;
        end
      end
      Checking: begin
        if (checker_done) begin
          state_d = Done;
        end
      end
      Done: begin
        state_d = Done;
      end
      // Invalid and any unused encoding stay trapped and keep the alert raised
      default: begin
        fsm_alert = 1'b1;
        state_d   = Invalid;
      end
    endcase

    // Every done signal has a window of states where it may legally appear
    if ((checker_done && !(state_q inside {Checking, Done})) ||
        (counter_done && state_q == ReadingLow) ||
        (hash_done_i && !(state_q inside {ReadingHigh, RomAhead}))) begin
      state_d = Invalid;
    end

    if (hash_err_i || checker_alert || counter_lost) begin
      state_d = Invalid;
    end
  end

  // Top words are snooped off the ROM bus as the counter holds them
  assign rel_addr = counter_data_addr - AddrW'(LowCount);
  assign exp_vld  = (state_q inside {ReadingHigh, KmacAhead}) & ~counter_done;

  // Valid rises behind each low-region read and falls once the engine takes the word
  always_comb begin
    hash_vld_d = hash_vld_q;
    if (hash_ready_i) begin
      hash_vld_d = 1'b0;
    end
    if (counter_req && state_q == ReadingLow && !counter_lnt) begin
      hash_vld_d = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hash_vld_q <= 1'b0;
      start_q    <= 1'b0;
    end else begin
      hash_vld_q <= hash_vld_d;
      // Comparator starts in the first cycle spent in Checking
      start_q    <= (state_q != Checking) && (state_d == Checking);
    end
  end

  // Top words are not hashed, so the counter never waits on the engine there
  assign counter_data_rdy = hash_ready_i | (state_q inside {ReadingHigh, KmacAhead});

  assign hash_valid_o = hash_vld_q;
  assign hash_last_o  = counter_lnt;
  assign hash_data_o  = rom_data_i;

  assign rom_req_o  = counter_req;
  assign rom_addr_o = counter_read_addr;

  assign in_done        = state_q == Done;
  assign done_o         = in_done;
  assign good_o         = checker_good;
  assign keymgr_valid_o = in_done;
  assign keymgr_data_o  = digest_o;

  // Once the check is over the counter must never fall back out of done
  assign counter_lost = in_done & ~counter_done;
  assign alert_o      = fsm_alert | checker_alert | counter_lost;

endmodule

// ==== src/rom_ctrl_compare.sv ====
// Digest registers and comparator
`timescale 1ns/10ps

module rom_ctrl_compare (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             start_i,
  input  logic                             digest_vld_i,
  input  logic                             exp_vld_i,
  input  logic [rom_ctrl_pkg::DigestW-1:0] digest_i,
  input  logic [31:0]                      exp_word_i,
  input  logic [rom_ctrl_pkg::IdxW-1:0]    exp_idx_i,
  output logic                             done_o,
  output logic                             good_o,
  output logic                             alert_o,
  output logic [rom_ctrl_pkg::DigestW-1:0] digest_o,
  output logic [rom_ctrl_pkg::DigestW-1:0] exp_digest_o
);
  import rom_ctrl_pkg::*;

  logic [TopCount-1:0][31:0] digest_q;
  logic [TopCount-1:0][31:0] exp_q;
  logic [IdxW-1:0]           idx_q;
  logic                      busy_q;
  logic                      finished_q;
  logic                      done_q;
  logic                      good_q;
  logic                      eq_q;
  logic                      word_eq;
  logic                      last_word;

  // Computed digest arrives in one go, the expected one word by word
  always_ff @(posedge clk_i) begin
    if (digest_vld_i) begin
      digest_q <= digest_i;
    end
    if (exp_vld_i) begin
      exp_q[exp_idx_i] <= exp_word_i;
    end
  end

  assign word_eq   = digest_q[idx_q] == exp_q[idx_q];
  assign last_word = idx_q == IdxW'(TopCount - 1);

  // The check runs exactly once per reset, so any second start is suspicious
  assign alert_o = start_i & (busy_q | finished_q);

  assign done_o       = done_q;
  assign good_o       = good_q;
  assign digest_o     = digest_q;
  assign exp_digest_o = exp_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      idx_q      <= '0;
      busy_q     <= 1'b0;
      finished_q <= 1'b0;
      done_q     <= 1'b0;
      good_q     <= 1'b0;
      eq_q       <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (start_i && !busy_q && !finished_q) begin
        busy_q <= 1'b1;
        idx_q  <= '0;
        eq_q   <= 1'b1;
      end else if (busy_q) begin
        // One word per cycle, folding each result into the running match
        eq_q  <= eq_q & word_eq;
        idx_q <= idx_q + IdxW'(1);
        if (last_word) begin
          busy_q     <= 1'b0;
          finished_q <= 1'b1;
          done_q     <= 1'b1;
          good_q     <= eq_q & word_eq;
        end
      end
    end
  end

endmodule

// ==== src/rom_ctrl_hash.sv ====
// ROM digest engine
`timescale 1ns/10ps

module rom_ctrl_hash (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             valid_i,
  input  logic                             last_i,
  input  logic [31:0]                      data_i,
  output logic                             ready_o,
  output logic                             done_o,
  output logic                             err_o,
  output logic [rom_ctrl_pkg::DigestW-1:0] digest_o
);
  import rom_ctrl_pkg::*;

  logic [TopCount-1:0][31:0] st_q;
  logic [AddrW-1:0]          cnt_q;
  logic [IdxW-1:0]           round_q;
  logic [IdxW-1:0]           next_round;
  logic [IdxW-1:0]           word_idx;
  logic                      cool_q;
  logic                      fin_q;
  logic                      done_q;
  logic                      err_q;
  logic                      accept;

  function automatic logic [31:0] rotl(input logic [31:0] x, input int unsigned amt);
    rotl = (x << amt) | (x >> (32 - amt));
  endfunction

  // Ready drops for one cycle after every accepted word and during finalisation
  assign ready_o = ~cool_q & ~fin_q;
  assign accept  = valid_i & ready_o;

  // TopCount is a power of two, so the low count bits give n modulo TopCount
  assign word_idx   = cnt_q[IdxW-1:0];
  assign next_round = round_q + IdxW'(1);

  // Word 0 of the state sits in the low 32 bits of the digest
  assign digest_o = st_q;
  assign done_o   = done_q;
  assign err_o    = err_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int k = 0; k < TopCount; k++) begin
        st_q[k] <= IvBase + 32'(k);
      end
      cnt_q   <= '0;
      round_q <= '0;
      cool_q  <= 1'b0;
      fin_q   <= 1'b0;
      done_q  <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      cool_q <= accept;
      done_q <= 1'b0;
      // Input offered while finalising means the stream overran its last word
      if (valid_i && fin_q) begin
        err_q <= 1'b1;
      end
      if (accept) begin
        st_q[word_idx] <= (rotl(st_q[word_idx], AbsorbRot) ^ data_i) + 32'(cnt_q);
        cnt_q          <= cnt_q + AddrW'(1);
        if (last_i) begin
          fin_q   <= 1'b1;
          round_q <= '0;
        end
      end else if (fin_q) begin
        // One round per cycle, each reading the current value of its neighbour
        st_q[round_q] <= st_q[round_q] ^ rotl(st_q[next_round], FinalRot);
        round_q       <= next_round;
        if (round_q == IdxW'(TopCount - 1)) begin
          fin_q  <= 1'b0;
          done_q <= 1'b1;
          cnt_q  <= '0;
        end
      end
    end
  end

endmodule

// ==== src/rom_ctrl_counter.sv ====
// ROM read address generator
`timescale 1ns/10ps

module rom_ctrl_counter (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           data_rdy_i,
  output logic                           done_o,
  output logic                           read_req_o,
  output logic                           data_last_nontop_o,
  output logic [rom_ctrl_pkg::AddrW-1:0] read_addr_o,
  output logic [rom_ctrl_pkg::AddrW-1:0] data_addr_o
);
  import rom_ctrl_pkg::*;

  logic             vld_q;
  logic             done_q;
  logic [AddrW-1:0] data_addr_q;
  logic [AddrW-1:0] next_addr;
  logic             go;
  logic             last_held;

  // The held word is the one on the ROM data bus this cycle
  // We may move on once it has been taken, or when nothing is held yet
  assign go        = data_rdy_i | ~vld_q;
  assign last_held = vld_q & (data_addr_q == AddrW'(RomDepth - 1));

  // Nothing held only happens before the first read, so address zero is reused
  assign next_addr = vld_q ? data_addr_q + AddrW'(1) : data_addr_q;

  // While stalled the held address is read again so that the ROM output stays put
  assign read_req_o  = ~done_q & ~(go & last_held);
  assign read_addr_o = go ? next_addr : data_addr_q;
  assign data_addr_o = data_addr_q;

  // Last word of the low region, which closes the digest stream
  assign data_last_nontop_o = vld_q & (data_addr_q == AddrW'(LowCount - 1));
  assign done_o             = done_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vld_q       <= 1'b0;
      done_q      <= 1'b0;
      data_addr_q <= '0;
    end else if (!done_q && go) begin
      if (last_held) begin
        // Final word released, so stop reading for good
        vld_q  <= 1'b0;
        done_q <= 1'b1;
      end else begin
        vld_q       <= 1'b1;
        data_addr_q <= next_addr;
      end
    end
  end

endmodule

// ==== src/rom_ctrl_pkg.sv ====
// ROM checker shared definitions

package rom_ctrl_pkg;

  // ROM geometry in 32-bit words
  localparam int RomDepth = 64;
  localparam int TopCount = 8;
  localparam int AddrW    = 6;
  localparam int IdxW     = 3;

  // Words below the top region are streamed into the digest engine
  localparam int LowCount = RomDepth - TopCount;
  localparam int DigestW  = TopCount * 32;

  // Digest word k starts at IvBase + k
  localparam logic [31:0] IvBase = 32'h6a09_e667;

  // Rotate amounts for the absorb and finalise steps
  localparam int unsigned AbsorbRot = 5;
  localparam int unsigned FinalRot  = 7;

  // Check sequencer states, linear apart from the RomAhead/KmacAhead race
  typedef enum logic [2:0] {
    ReadingLow,
    ReadingHigh,
    RomAhead,
    KmacAhead,
    Checking,
    Done,
    Invalid
  } fsm_state_e;

endpackage
